//--- Makefile
# Verilator build for the disk drive selector

VERILATOR ?= verilator
FILELIST  ?= build.f
TOP       ?= tb_drive_top
RTL_TOP   ?= drive_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_drive_top.sv
// ##################################################
// testbench for the disk drive selector
// clock and reset, request stimulus, reference model,
// reply monitor, compare task, timeout and verdict
// ##################################################

`timescale 1ns/10ps

module tb_drive_top;

   localparam int REQ_CYCLES = 700;
   localparam int NUM_REQS   = 24;
   localparam int TIMEOUT    = NUM_REQS * REQ_CYCLES + 500;

   logic                  clk_sys;
   logic                  rst_i;
   drive_pkg::drive_vec_t img_mounted_i;
   logic [31:0]           img_size_i;
   logic                  img_type_i;
   logic [7:0]            par_data_i;
   logic                  par_stb_i;
   logic [7:0]            par_data_o;
   logic                  par_stb_o;
   drive_pkg::lba_t       sd_lba_o;
   drive_pkg::blk_cnt_t   sd_blk_cnt_o;
   logic                  sd_rd_o;
   logic                  sd_ack_i;
   drive_pkg::buff_addr_t sd_buff_addr_i;
   logic [7:0]            sd_buff_dout_i;
   logic                  sd_buff_wr_i;
   logic                  iec_data_o;
   drive_pkg::drive_vec_t led_o;

   int          errors     = 0;
   int          mon_errors = 0;
   int          checks     = 0;
   int          cycles     = 0;
   int          pairs_seen = 0;
   int          rd_seen    = 0;
   logic        stat_half  = 1'b0;
   logic        rd_prev    = 1'b0;
   logic [7:0]  stat_got;
   logic [7:0]  data_got;
   logic [31:0] lba_got;
   logic [5:0]  blk_got;
   // image type per drive as the host mounted it
   logic        drive_type [4];

   drive_top i_dut (.*);

   tb_sd_model i_sd (
      .clk_sys(clk_sys), .rst_i(rst_i),
      .sd_rd_i(sd_rd_o), .sd_lba_i(sd_lba_o), .sd_ack_o(sd_ack_i),
      .sd_buff_addr_o(sd_buff_addr_i), .sd_buff_dout_o(sd_buff_dout_i),
      .sd_buff_wr_o(sd_buff_wr_i)
   );

   initial begin
      clk_sys = 1'b0;
      forever #5 clk_sys = ~clk_sys;
   end

   // ##################################################
   // reference model
   function automatic int zone_spt(input int trk);
      if (trk <= 17) return 21;
      if (trk <= 24) return 19;
      if (trk <= 30) return 18;
      return 17;
   endfunction

   function automatic logic [7:0] expect_reply(input logic [1:0] drv, input int trk,
         input int sec, output logic [31:0] lba, output logic [5:0] blk,
         output logic [7:0] data);
      int idx;
      int base;
      lba  = '0;
      blk  = '0;
      data = 8'h00;
      if (int'(drv) >= drive_pkg::NUM_DRIVES) return drive_pkg::STAT_BAD;
      if (drive_type[drv]) begin
         if (trk < 1 || trk > 80 || sec >= 40) return drive_pkg::STAT_BAD;
         idx  = (trk - 1) * 40 + sec;
         lba  = 32'((idx / 2) * 2);
         blk  = 6'd1;
         data = 8'((lba + 32'(idx % 2)) * 32'd7);
      end else begin
         if (trk < 1 || trk > 35 || sec >= zone_spt(trk)) return drive_pkg::STAT_BAD;
         base = 0;
         for (int t = 1; t < trk; t++) base += zone_spt(t);
         lba  = 32'(base + sec);
         data = 8'(lba * 32'd7);
      end
      return drive_pkg::STAT_OK;
   endfunction

   // ##################################################
   // reply and sd read monitor
   always @(posedge clk_sys) begin
      if (!rst_i) begin
         if (stat_half && !par_stb_o) begin
            $display("data byte did not follow the status byte at %0t", $time);
            mon_errors++;
         end
         if (par_stb_o && !stat_half) begin
            stat_got  = par_data_o;
            stat_half = 1'b1;
         end else if (par_stb_o) begin
            data_got  = par_data_o;
            stat_half = 1'b0;
            pairs_seen++;
         end else begin
            stat_half = 1'b0;
         end
         if (sd_rd_o && !rd_prev) begin
            lba_got = sd_lba_o;
            blk_got = sd_blk_cnt_o;
            rd_seen++;
         end
         rd_prev = sd_rd_o;
      end
   end

   always @(posedge clk_sys) begin
      cycles++;
      if (cycles > TIMEOUT) begin
         $display("timeout, the run did not finish within %0d cycles", TIMEOUT);
         $display("checks %0d errors %0d", checks, errors + mon_errors + 1);
         $display("*** FAILED ***");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
         input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("MISMATCH %0t %s got %0h expected %0h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic next_cycle();
      @(posedge clk_sys);
      #1;
   endtask

   task automatic send_byte(input logic [7:0] b);
      next_cycle();
      par_data_i = b;
      par_stb_i  = 1'b1;
      next_cycle();
      par_stb_i  = 1'b0;
   endtask

   task automatic mount_image(input logic [1:0] drv, input logic typ, input logic [31:0] size);
      next_cycle();
      img_mounted_i = drive_pkg::drive_vec_t'(1) << drv;
      img_size_i    = size;
      img_type_i    = typ;
      next_cycle();
      img_mounted_i = '0;
      if (size != 32'd0) drive_type[drv] = typ;
   endtask

   task automatic run_request(input logic [1:0] drv, input int trk, input int sec);
      logic [7:0]  exp_stat;
      logic [31:0] exp_lba;
      logic [5:0]  exp_blk;
      logic [7:0]  exp_data;
      logic        ok;
      int          pairs_before;
      int          rd_before;
      int          limit;
      int          n;
      exp_stat     = expect_reply(drv, trk, sec, exp_lba, exp_blk, exp_data);
      ok           = (exp_stat == drive_pkg::STAT_OK);
      limit        = ok ? REQ_CYCLES : 40;
      pairs_before = pairs_seen;
      rd_before    = rd_seen;
      send_byte(8'(drv));
      send_byte(8'(trk));
      send_byte(8'(sec));
      if (ok) begin
         while (!sd_rd_o) next_cycle();
         check_value("led_o", 32'(led_o), 32'(1) << drv);
         check_value("iec_data_o", 32'(iec_data_o), 32'd0);
         // a full command while busy must be dropped
         send_byte(8'h00);
         send_byte(8'h01);
         send_byte(8'h00);
      end
      n = 0;
      while (pairs_seen == pairs_before && n < limit) begin
         next_cycle();
         n++;
      end
      if (pairs_seen == pairs_before) begin
         $display("no reply within %0d cycles for drive %0d track %0d sector %0d",
                  limit, drv, trk, sec);
         errors++;
      end else begin
         check_value("par_data_o status", 32'(stat_got), 32'(exp_stat));
         check_value("par_data_o data", 32'(data_got), 32'(exp_data));
         if (ok) begin
            check_value("sd_lba_o", lba_got, exp_lba);
            check_value("sd_blk_cnt_o", 32'(blk_got), 32'(exp_blk));
         end
      end
      repeat (40) next_cycle();
      check_value("reply pairs", 32'(pairs_seen - pairs_before), 32'd1);
      check_value("sd_rd_o rises", 32'(rd_seen - rd_before), 32'(ok));
   endtask

   // ##################################################
   // test sequence
   initial begin
      rst_i         = 1'b1;
      img_mounted_i = '0;
      img_size_i    = '0;
      img_type_i    = 1'b0;
      par_data_i    = '0;
      par_stb_i     = 1'b0;
      for (int i = 0; i < 4; i++) drive_type[i] = 1'b0;
      repeat (3) @(posedge clk_sys);
      #1;
      rst_i = 1'b0;
      check_value("sd_rd_o", 32'(sd_rd_o), 32'd0);
      check_value("par_stb_o", 32'(par_stb_o), 32'd0);
      check_value("led_o", 32'(led_o), 32'd0);
      check_value("iec_data_o", 32'(iec_data_o), 32'd1);

      // gcr zones and edges
      mount_image(2'd0, 1'b0, 32'd174848);
      run_request(2'd0, 1, 0);
      run_request(2'd0, 17, 20);
      run_request(2'd0, 18, 0);
      run_request(2'd0, 24, 18);
      run_request(2'd0, 25, 0);
      run_request(2'd0, 30, 17);
      run_request(2'd0, 31, 0);
      run_request(2'd0, 35, 16);

      // mfm with even and odd logical index
      mount_image(2'd1, 1'b1, 32'd819200);
      run_request(2'd1, 1, 0);
      run_request(2'd1, 1, 1);
      run_request(2'd1, 2, 3);
      run_request(2'd1, 40, 17);
      run_request(2'd1, 80, 39);

      // rejected requests
      run_request(2'd0, 36, 0);
      run_request(2'd0, 1, 21);
      run_request(2'd0, 18, 19);
      run_request(2'd0, 0, 0);
      run_request(2'd1, 1, 40);
      run_request(2'd1, 81, 0);
      run_request(2'd1, 0, 5);
      run_request(2'd3, 1, 0);

      // remount switches the mapping and size 0 keeps it
      mount_image(2'd0, 1'b1, 32'd819200);
      run_request(2'd0, 2, 3);
      mount_image(2'd0, 1'b0, 32'd0);
      run_request(2'd0, 2, 4);
      mount_image(2'd0, 1'b0, 32'd174848);
      run_request(2'd0, 2, 4);

      $display("checks %0d errors %0d", checks, errors + mon_errors);
      if (errors + mon_errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- bench/tb_sd_model.sv
// ##################################################
// sd host model for the drive testbench
// answers block reads after a random delay with a
// byte pattern derived from the block address
// ##################################################

`timescale 1ns/10ps

module tb_sd_model (
   input  logic        clk_sys,
   input  logic        rst_i,
   input  logic        sd_rd_i,
   input  logic [31:0] sd_lba_i,
   output logic        sd_ack_o,
   output logic [8:0]  sd_buff_addr_o,
   output logic [7:0]  sd_buff_dout_o,
   output logic        sd_buff_wr_o
);

   logic [31:0] rnd;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   initial begin
      logic [31:0] blk;
      logic [31:0] val;
      int          dly;
      rnd            = 32'h1af2;
      sd_ack_o       = 1'b0;
      sd_buff_addr_o = '0;
      sd_buff_dout_o = '0;
      sd_buff_wr_o   = 1'b0;
      forever begin
         @(posedge clk_sys);
         if (!rst_i && sd_rd_i) begin
            blk = sd_lba_i;
            rnd = xorshift32(rnd);
            dly = int'(rnd[2:0]) + 1;
            repeat (dly) @(posedge clk_sys);
            #1;
            sd_ack_o = 1'b1;
            // byte k of 256-byte unit L is the low byte of L*7+k
            for (int k = 0; k < 512; k++) begin
               val            = (blk + 32'(k / 256)) * 32'd7 + 32'(k % 256);
               sd_buff_wr_o   = 1'b1;
               sd_buff_addr_o = 9'(k);
               sd_buff_dout_o = val[7:0];
               @(posedge clk_sys);
               #1;
            end
            sd_buff_wr_o = 1'b0;
            sd_ack_o     = 1'b0;
         end
      end
   end

endmodule

//--- build.f
common/drive_pkg.sv
hdl/cmd_receiver.sv
gcr/gcr_drive.sv
mfm/mfm_drive.sv
hdl/drive_select.sv
hdl/drive_top.sv
bench/tb_sd_model.sv
bench/tb_drive_top.sv

//--- common/drive_pkg.sv
// ##################################################
// shared definitions of the disk drive selector
// drive count, gcr and mfm geometry limits,
// reply status codes and the common vector types
// ##################################################

package drive_pkg;

   localparam int NUM_DRIVES = 2;

   typedef logic [1:0]            drive_id_t;
   typedef logic [NUM_DRIVES-1:0] drive_vec_t;
   typedef logic [7:0]            track_t;
   typedef logic [7:0]            sector_t;
   typedef logic [31:0]           lba_t;
   typedef logic [5:0]            blk_cnt_t;
   typedef logic [8:0]            buff_addr_t;

   // gcr zoned layout, zone 1 is the outer edge
   localparam track_t  GCR_TRACKS = 8'd35;
   localparam track_t  ZONE1_LAST = 8'd17;
   localparam track_t  ZONE2_LAST = 8'd24;
   localparam track_t  ZONE3_LAST = 8'd30;
   localparam sector_t ZONE1_SPT  = 8'd21;
   localparam sector_t ZONE2_SPT  = 8'd19;
   localparam sector_t ZONE3_SPT  = 8'd18;
   localparam sector_t ZONE4_SPT  = 8'd17;

   // mfm fixed layout
   localparam track_t  MFM_TRACKS  = 8'd80;
   localparam sector_t MFM_SECTORS = 8'd40;

   localparam logic [7:0] STAT_OK  = 8'h00;
   localparam logic [7:0] STAT_BAD = 8'hff;

   // sectors per track for a gcr track number
   function automatic sector_t gcr_spt(input track_t trk);
      sector_t spt;
      if (trk <= ZONE1_LAST) begin
         spt = ZONE1_SPT;
      end else if (trk <= ZONE2_LAST) begin
         spt = ZONE2_SPT;
      end else if (trk <= ZONE3_LAST) begin
         spt = ZONE3_SPT;
      end else begin
         spt = ZONE4_SPT;
      end
      return spt;
   endfunction

endpackage

//--- gcr/gcr_drive.sv
// ##################################################
// gcr engine for zoned 35-track images
// request check, zone table walk to the block
// address and the sd block read
// ##################################################

`timescale 1ns/10ps

module gcr_drive (
   input  logic                  clk_sys,
   input  logic                  rst_i,
   input  logic                  req_i,
   input  drive_pkg::track_t     track_i,
   input  drive_pkg::sector_t    sector_i,
   output logic                  sd_rd_o,
   input  logic                  sd_ack_i,
   output drive_pkg::lba_t       lba_o,
   input  drive_pkg::buff_addr_t sd_buff_addr_i,
   input  logic [7:0]            sd_buff_dout_i,
   input  logic                  sd_buff_wr_i,
   output logic                  busy_o,
   output logic                  done_o,
   output logic [7:0]            status_o,
   output logic [7:0]            byte_o
);

   typedef enum logic [2:0] {IDLE, WALK, READ, WAIT_END, DONE} state_t;

   state_t             state;
   drive_pkg::track_t  track_q;
   drive_pkg::track_t  walk_trk;
   drive_pkg::sector_t sector_q;
   drive_pkg::lba_t    acc;
   logic               req_bad;

   assign req_bad = (track_i == 8'd0) || (track_i > drive_pkg::GCR_TRACKS) ||
                    (sector_i >= drive_pkg::gcr_spt(track_i));

   assign sd_rd_o = (state == READ);
   assign busy_o  = (state != IDLE);
   assign done_o  = (state == DONE);

   // ##################################################
   // control
   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE:     if (req_i) state <= req_bad ? DONE : WALK;
            WALK:     if (walk_trk == track_q) state <= READ;
            READ:     if (sd_ack_i) state <= WAIT_END;
            WAIT_END: if (!sd_ack_i) state <= DONE;
            default:  state <= IDLE;
         endcase
      end
   end

   // ##################################################
   // address walk and byte capture
   always_ff @(posedge clk_sys) begin
      case (state)
         IDLE: begin
            if (req_i) begin
               track_q  <= track_i;
               sector_q <= sector_i;
               walk_trk <= 8'd1;
               acc      <= '0;
               status_o <= req_bad ? drive_pkg::STAT_BAD : drive_pkg::STAT_OK;
               byte_o   <= 8'h00;
            end
         end
         WALK: begin
            // one track per cycle, sum of all tracks before the target
            if (walk_trk == track_q) begin
               lba_o <= acc + drive_pkg::lba_t'(sector_q);
            end else begin
               acc      <= acc + drive_pkg::lba_t'(drive_pkg::gcr_spt(walk_trk));
               walk_trk <= walk_trk + 8'd1;
            end
         end
         READ, WAIT_END: begin
            if (sd_ack_i && sd_buff_wr_i && sd_buff_addr_i == '0) begin
               byte_o <= sd_buff_dout_i;
            end
         end
         default: begin
         end
      endcase
   end

endmodule

//--- hdl/cmd_receiver.sv
// ##################################################
// parallel port command receiver
// collects drive, track and sector bytes and
// issues one request pulse per complete command
// ##################################################

`timescale 1ns/10ps

module cmd_receiver (
   input  logic                clk_sys,
   input  logic                rst_i,
   input  logic [7:0]          par_data_i,
   input  logic                par_stb_i,
   input  logic                busy_i,
   output logic                req_o,
   output drive_pkg::drive_id_t req_drive_o,
   output drive_pkg::track_t   req_track_o,
   output drive_pkg::sector_t  req_sector_o
);

   logic [1:0] byte_cnt;
   logic       take_byte;

   // strobes during an outstanding request are dropped
   assign take_byte = par_stb_i && !busy_i;

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         byte_cnt <= 2'd0;
         req_o    <= 1'b0;
      end else begin
         req_o <= 1'b0;
         if (busy_i) begin
            byte_cnt <= 2'd0;
         end else if (par_stb_i) begin
            if (byte_cnt == 2'd2) begin
               byte_cnt <= 2'd0;
               req_o    <= 1'b1;
            end else begin
               byte_cnt <= byte_cnt + 2'd1;
            end
         end
      end
   end

   // field registers
   always_ff @(posedge clk_sys) begin
      if (take_byte) begin
         case (byte_cnt)
            2'd0:    req_drive_o  <= drive_pkg::drive_id_t'(par_data_i[1:0]);
            2'd1:    req_track_o  <= par_data_i;
            default: req_sector_o <= par_data_i;
         endcase
      end
   end

endmodule

//--- hdl/drive_select.sv
// ##################################################
// drive selector output side
// per-drive image types, request routing, sd port
// mux, reply byte sender and activity outputs
// ##################################################

`timescale 1ns/10ps

module drive_select (
   input  logic                   clk_sys,
   input  logic                   rst_i,
   input  drive_pkg::drive_vec_t  img_mounted_i,
   input  logic [31:0]            img_size_i,
   input  logic                   img_type_i,
   input  logic                   req_i,
   input  drive_pkg::drive_id_t   req_drive_i,
   output logic                   gcr_req_o,
   output logic                   mfm_req_o,
   input  logic                   gcr_rd_i,
   input  drive_pkg::lba_t        gcr_lba_i,
   input  logic                   gcr_busy_i,
   input  logic                   gcr_done_i,
   input  logic [7:0]             gcr_status_i,
   input  logic [7:0]             gcr_byte_i,
   input  logic                   mfm_rd_i,
   input  drive_pkg::lba_t        mfm_lba_i,
   input  logic                   mfm_busy_i,
   input  logic                   mfm_done_i,
   input  logic [7:0]             mfm_status_i,
   input  logic [7:0]             mfm_byte_i,
   output drive_pkg::lba_t        sd_lba_o,
   output drive_pkg::blk_cnt_t    sd_blk_cnt_o,
   output logic                   sd_rd_o,
   output logic [7:0]             par_data_o,
   output logic                   par_stb_o,
   output logic                   iec_data_o,
   output drive_pkg::drive_vec_t  led_o,
   output logic                   busy_o
);

   drive_pkg::drive_vec_t dtype_q;
   drive_pkg::drive_id_t  act_drive_q;
   logic                  act_type_q;
   logic                  req_valid;
   logic                  req_type;
   logic                  bad_req;
   logic                  reply_pend;
   logic [7:0]            byte_q;

   // type of the requested drive, invalid above the drive count
   always_comb begin
      req_valid = 1'b0;
      req_type  = 1'b0;
      for (int i = 0; i < drive_pkg::NUM_DRIVES; i++) begin
         if (req_drive_i == drive_pkg::drive_id_t'(i)) begin
            req_valid = 1'b1;
            req_type  = dtype_q[i];
         end
      end
   end

   assign gcr_req_o = req_i && req_valid && !req_type;
   assign mfm_req_o = req_i && req_valid && req_type;
   assign bad_req   = req_i && !req_valid;

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         dtype_q     <= '0;
         act_drive_q <= '0;
         act_type_q  <= 1'b0;
      end else begin
         for (int i = 0; i < drive_pkg::NUM_DRIVES; i++) begin
            if (img_mounted_i[i] && img_size_i != 32'd0) dtype_q[i] <= img_type_i;
         end
         if (req_i && req_valid) begin
            act_drive_q <= req_drive_i;
            act_type_q  <= req_type;
         end
      end
   end

   // ##################################################
   // sd port, mfm blocks are two 256-byte units
   assign sd_rd_o      = gcr_rd_i | mfm_rd_i;
   assign sd_lba_o     = act_type_q ? {mfm_lba_i[30:0], 1'b0} : gcr_lba_i;
   assign sd_blk_cnt_o = act_type_q ? drive_pkg::blk_cnt_t'(1) : drive_pkg::blk_cnt_t'(0);

   // open-collector data pull and led of the active drive
   assign iec_data_o = ~gcr_busy_i & ~mfm_busy_i;

   always_comb begin
      led_o = '0;
      for (int i = 0; i < drive_pkg::NUM_DRIVES; i++) begin
         if (act_drive_q == drive_pkg::drive_id_t'(i)) led_o[i] = gcr_busy_i | mfm_busy_i;
      end
   end

   assign busy_o = req_i | gcr_busy_i | mfm_busy_i | reply_pend;

   // ##################################################
   // reply sender, status byte then data byte
   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         par_stb_o  <= 1'b0;
         reply_pend <= 1'b0;
      end else begin
         par_stb_o <= reply_pend | gcr_done_i | mfm_done_i | bad_req;
         reply_pend <= !reply_pend && (gcr_done_i || mfm_done_i || bad_req);
      end
   end

   always_ff @(posedge clk_sys) begin
      if (reply_pend) begin
         par_data_o <= byte_q;
      end else if (gcr_done_i) begin
         par_data_o <= gcr_status_i;
         byte_q     <= gcr_byte_i;
      end else if (mfm_done_i) begin
         par_data_o <= mfm_status_i;
         byte_q     <= mfm_byte_i;
      end else if (bad_req) begin
         par_data_o <= drive_pkg::STAT_BAD;
         byte_q     <= 8'h00;
      end
   end

endmodule

//--- hdl/drive_top.sv
// ##################################################
// disk drive selector top level
// receiver, gcr and mfm engines and the selector
// ##################################################

`timescale 1ns/10ps

module drive_top (
   input  logic                  clk_sys,
   input  logic                  rst_i,
   input  drive_pkg::drive_vec_t img_mounted_i,
   input  logic [31:0]           img_size_i,
   input  logic                  img_type_i,
   input  logic [7:0]            par_data_i,
   input  logic                  par_stb_i,
   output logic [7:0]            par_data_o,
   output logic                  par_stb_o,
   output drive_pkg::lba_t       sd_lba_o,
   output drive_pkg::blk_cnt_t   sd_blk_cnt_o,
   output logic                  sd_rd_o,
   input  logic                  sd_ack_i,
   input  drive_pkg::buff_addr_t sd_buff_addr_i,
   input  logic [7:0]            sd_buff_dout_i,
   input  logic                  sd_buff_wr_i,
   output logic                  iec_data_o,
   output drive_pkg::drive_vec_t led_o
);

   logic                 req;
   logic                 busy;
   drive_pkg::drive_id_t req_drive;
   drive_pkg::track_t    req_track;
   drive_pkg::sector_t   req_sector;
   logic                 gcr_req,  mfm_req;
   logic                 gcr_rd,   mfm_rd;
   drive_pkg::lba_t      gcr_lba,  mfm_lba;
   logic                 gcr_busy, mfm_busy;
   logic                 gcr_done, mfm_done;
   logic [7:0]           gcr_status, mfm_status;
   logic [7:0]           gcr_byte, mfm_byte;

   cmd_receiver i_rx (
      .clk_sys(clk_sys), .rst_i(rst_i),
      .par_data_i(par_data_i), .par_stb_i(par_stb_i), .busy_i(busy),
      .req_o(req), .req_drive_o(req_drive),
      .req_track_o(req_track), .req_sector_o(req_sector)
   );

   gcr_drive i_gcr (
      .clk_sys(clk_sys), .rst_i(rst_i),
      .req_i(gcr_req), .track_i(req_track), .sector_i(req_sector),
      .sd_rd_o(gcr_rd), .sd_ack_i(sd_ack_i), .lba_o(gcr_lba),
      .sd_buff_addr_i(sd_buff_addr_i), .sd_buff_dout_i(sd_buff_dout_i),
      .sd_buff_wr_i(sd_buff_wr_i),
      .busy_o(gcr_busy), .done_o(gcr_done), .status_o(gcr_status), .byte_o(gcr_byte)
   );

   mfm_drive i_mfm (
      .clk_sys(clk_sys), .rst_i(rst_i),
      .req_i(mfm_req), .track_i(req_track), .sector_i(req_sector),
      .sd_rd_o(mfm_rd), .sd_ack_i(sd_ack_i), .lba_o(mfm_lba),
      .sd_buff_addr_i(sd_buff_addr_i), .sd_buff_dout_i(sd_buff_dout_i),
      .sd_buff_wr_i(sd_buff_wr_i),
      .busy_o(mfm_busy), .done_o(mfm_done), .status_o(mfm_status), .byte_o(mfm_byte)
   );

   drive_select i_sel (
      .clk_sys(clk_sys), .rst_i(rst_i),
      .img_mounted_i(img_mounted_i), .img_size_i(img_size_i), .img_type_i(img_type_i),
      .req_i(req), .req_drive_i(req_drive), .gcr_req_o(gcr_req), .mfm_req_o(mfm_req),
      .gcr_rd_i(gcr_rd), .gcr_lba_i(gcr_lba), .gcr_busy_i(gcr_busy),
      .gcr_done_i(gcr_done), .gcr_status_i(gcr_status), .gcr_byte_i(gcr_byte),
      .mfm_rd_i(mfm_rd), .mfm_lba_i(mfm_lba), .mfm_busy_i(mfm_busy),
      .mfm_done_i(mfm_done), .mfm_status_i(mfm_status), .mfm_byte_i(mfm_byte),
      .sd_lba_o(sd_lba_o), .sd_blk_cnt_o(sd_blk_cnt_o), .sd_rd_o(sd_rd_o),
      .par_data_o(par_data_o), .par_stb_o(par_stb_o),
      .iec_data_o(iec_data_o), .led_o(led_o), .busy_o(busy)
   );

endmodule

//--- mfm/mfm_drive.sv
// ##################################################
// mfm engine for 80-track images
// request check, 512-byte block and half select,
// sd block read
// ##################################################

`timescale 1ns/10ps

module mfm_drive (
   input  logic                  clk_sys,
   input  logic                  rst_i,
   input  logic                  req_i,
   input  drive_pkg::track_t     track_i,
   input  drive_pkg::sector_t    sector_i,
   output logic                  sd_rd_o,
   input  logic                  sd_ack_i,
   output drive_pkg::lba_t       lba_o,
   input  drive_pkg::buff_addr_t sd_buff_addr_i,
   input  logic [7:0]            sd_buff_dout_i,
   input  logic                  sd_buff_wr_i,
   output logic                  busy_o,
   output logic                  done_o,
   output logic [7:0]            status_o,
   output logic [7:0]            byte_o
);

   typedef enum logic [1:0] {IDLE, READ, WAIT_END, DONE} state_t;

   state_t      state;
   logic [15:0] trk_m1;
   logic [15:0] index;
   logic        half_q;
   logic        req_bad;

   // (track-1)*40 + sector, 40 = 32 + 8
   assign trk_m1 = {8'd0, track_i} - 16'd1;
   assign index  = (trk_m1 << 5) + (trk_m1 << 3) + {8'd0, sector_i};

   assign req_bad = (track_i == 8'd0) || (track_i > drive_pkg::MFM_TRACKS) ||
                    (sector_i >= drive_pkg::MFM_SECTORS);

   assign sd_rd_o = (state == READ);
   assign busy_o  = (state != IDLE);
   assign done_o  = (state == DONE);

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE:     if (req_i) state <= req_bad ? DONE : READ;
            READ:     if (sd_ack_i) state <= WAIT_END;
            WAIT_END: if (!sd_ack_i) state <= DONE;
            default:  state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_sys) begin
      if (state == IDLE && req_i) begin
         lba_o    <= drive_pkg::lba_t'(index[15:1]);
         half_q   <= index[0];
         status_o <= req_bad ? drive_pkg::STAT_BAD : drive_pkg::STAT_OK;
         byte_o   <= 8'h00;
      end else if ((state == READ || state == WAIT_END) && sd_ack_i && sd_buff_wr_i &&
                   sd_buff_addr_i == {half_q, 8'h00}) begin
         // odd sectors sit in the upper 256 bytes
         byte_o <= sd_buff_dout_i;
      end
   end

endmodule
